// ==== Bender.yml ====
package:
  name: fetch_stage1

export_include_dirs:
  - common

sources:
  - files:
      - common/fetchPkg.sv
      - predict/btb.sv
      - predict/branchPredictor.sv
      - predict/returnStack.sv
      - logic/instCache.sv
      - fetchStage1/fetchStage1.sv
  - target: test
    files:
      - verification/fetchStage1Tb.sv

// ==== common/fetchPkg.sv ====
// ==========================================================================
// Fetch stage types
// Control-instruction kinds held in the BTB and seen on the update port,
// plus the slot index used across the four-wide fetch bundle
// ==========================================================================

package fetchPkg;

  // Control-instruction kind as encoded in the CTI queue
  typedef enum logic [1:0] {
    CT_RETURN = 2'b00,  // Pops RAS
    CT_CALL   = 2'b01,  // Pushes RAS
    CT_JUMP   = 2'b10,  // Unconditional
    CT_COND   = 2'b11   // Direction from counters
  } ctrlType_t;

  // Position of an instruction inside a bundle
  typedef logic [1:0] slotIdx_t;

endpackage

// ==== common/fetch_defines.svh ====
// ==========================================================================
// Fetch stage sizes
// Address and data widths, bundle geometry and predictor table sizes
// ==========================================================================

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

`define SIZE_PC           32
`define INST_WIDTH        32
`define SLOT_COUNT        4
`define SLOT_BYTES        8   // Stride between slots
`define SLOT_SHIFT        3   // log2 of SLOT_BYTES
`define BUNDLE_SHIFT      5   // log2 of bytes per bundle
`define BUNDLE_BYTES      (`SLOT_COUNT * `SLOT_BYTES)
`define BUNDLE_WIDTH      (`SLOT_COUNT * `INST_WIDTH)

`define ICACHE_LINES      16  // One bundle per line
`define ICACHE_INDEX_BITS 4
`define BTB_SETS          8   // Entries per bank
`define BTB_INDEX_BITS    3
`define BP_ENTRIES        64
`define BP_INDEX_BITS     6
`define RAS_DEPTH         8
`define RAS_PTR_BITS      3

`endif

// ==== compile.f ====
+incdir+common
common/fetchPkg.sv
predict/btb.sv
predict/branchPredictor.sv
predict/returnStack.sv
logic/instCache.sv
fetchStage1/fetchStage1.sv
verification/fetchStage1Tb.sv

// ==== fetchStage1/fetchStage1.sv ====
// ==========================================================================
// Fetch stage 1
// Holds the fetch PC, reads a bundle and the predictors, and picks the
// next PC from recoveries, BTB/RAS targets or the sequential bundle
// ==========================================================================

`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetchStage1 import fetchPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stall_i,
  input  logic                     recoverFlag_i,
  input  logic [`SIZE_PC-1:0]      recoverPC_i,
  input  logic                     exceptionFlag_i,
  input  logic [`SIZE_PC-1:0]      exceptionPC_i,
  input  logic                     flagRecoverEX_i,
  input  logic [`SIZE_PC-1:0]      targetAddrEX_i,
  input  logic                     flagRecoverID_i,
  input  logic [`SIZE_PC-1:0]      targetAddrID_i,
  input  logic                     updateEn_i,
  input  logic [`SIZE_PC-1:0]      updatePC_i,
  input  logic [`SIZE_PC-1:0]      updateTargetAddr_i,
  input  ctrlType_t                updateBrType_i,
  input  logic                     updateDir_i,
  input  logic                     wrEnable_i,
  input  logic [`SIZE_PC-1:0]      wrAddr_i,
  input  logic [`BUNDLE_WIDTH-1:0] instBlock_i,
  output logic [`SIZE_PC-1:0]      pc_o,
  output logic [`BUNDLE_WIDTH-1:0] instructionBundle_o,
  output logic                     fs1Ready_o,
  output logic                     miss_o,
  output logic [`SIZE_PC-1:0]      missAddr_o,
  output logic                     btbHit0_o,
  output logic                     btbHit1_o,
  output logic                     btbHit2_o,
  output logic                     btbHit3_o,
  output logic [`SIZE_PC-1:0]      targetAddr0_o,
  output logic [`SIZE_PC-1:0]      targetAddr1_o,
  output logic [`SIZE_PC-1:0]      targetAddr2_o,
  output logic [`SIZE_PC-1:0]      targetAddr3_o,
  output logic                     prediction0_o,
  output logic                     prediction1_o,
  output logic                     prediction2_o,
  output logic                     prediction3_o
);

  logic [`SIZE_PC-1:0]    pc;
  logic [`SIZE_PC-1:0]    nextPc;
  logic [`SIZE_PC-1:0]    alignedPc;
  logic                   miss;

  // Predictor lookup results per slot
  logic [`SLOT_COUNT-1:0] btbHit;
  ctrlType_t              slotType   [`SLOT_COUNT];
  logic [`SIZE_PC-1:0]    btbTarget  [`SLOT_COUNT];
  logic [`SIZE_PC-1:0]    slotTarget [`SLOT_COUNT];
  logic [`SLOT_COUNT-1:0] prediction;
  logic [`SIZE_PC-1:0]    addrRas;

  logic [`SLOT_COUNT-1:0] slotValid;
  logic [`SLOT_COUNT-1:0] slotTaken;
  logic                   anyTaken;
  slotIdx_t               firstIdx;
  logic                   predictPath;   // Predicted or sequential next PC
  logic                   pushRas;
  logic                   popRas;
  logic [`SIZE_PC-1:0]    pushAddr;
  logic                   updateBtb;
  logic                   updateBp;

  // Conditional types train counters and only taken ones reach the BTB
  assign updateBp  = updateEn_i && (updateBrType_i == CT_COND);
  assign updateBtb = updateEn_i && ((updateBrType_i != CT_COND) || updateDir_i);

  btb btbInst (
    .clk                (clk),
    .reset              (reset),
    .pc_i               (pc),
    .updateEn_i         (updateBtb),
    .updatePC_i         (updatePC_i),
    .updateBrType_i     (updateBrType_i),
    .updateTargetAddr_i (updateTargetAddr_i),
    .btbHit0_o          (btbHit[0]),
    .btbHit1_o          (btbHit[1]),
    .btbHit2_o          (btbHit[2]),
    .btbHit3_o          (btbHit[3]),
    .ctrlType0_o        (slotType[0]),
    .ctrlType1_o        (slotType[1]),
    .ctrlType2_o        (slotType[2]),
    .ctrlType3_o        (slotType[3]),
    .targetAddr0_o      (btbTarget[0]),
    .targetAddr1_o      (btbTarget[1]),
    .targetAddr2_o      (btbTarget[2]),
    .targetAddr3_o      (btbTarget[3])
  );

  branchPredictor bpInst (
    .clk           (clk),
    .reset         (reset),
    .pc_i          (pc),
    .updateEn_i    (updateBp),
    .updatePC_i    (updatePC_i),
    .updateDir_i   (updateDir_i),
    .prediction0_o (prediction[0]),
    .prediction1_o (prediction[1]),
    .prediction2_o (prediction[2]),
    .prediction3_o (prediction[3])
  );

  returnStack rasInst (
    .clk        (clk),
    .reset      (reset),
    .push_i     (pushRas),
    .pushAddr_i (pushAddr),
    .pop_i      (popRas),
    .addrRAS_o  (addrRas)
  );

  instCache icacheInst (
    .clk          (clk),
    .reset        (reset),
    .addr_i       (pc),
    .wrEnable_i   (wrEnable_i),
    .wrAddr_i     (wrAddr_i),
    .instBlock_i  (instBlock_i),
    .instBundle_o (instructionBundle_o),
    .miss_o       (miss),
    .missAddr_o   (missAddr_o)
  );

  assign alignedPc = {pc[`SIZE_PC-1:`BUNDLE_SHIFT], {`BUNDLE_SHIFT{1'b0}}};

  // Slot qualification
  for (genvar s = 0; s < `SLOT_COUNT; s++) begin : genSlot
    assign slotValid[s]  = slotIdx_t'(s) >= pc[`BUNDLE_SHIFT-1:`SLOT_SHIFT];  // At or past entry
    assign slotTaken[s]  = slotValid[s] && btbHit[s] &&
                           ((slotType[s] != CT_COND) || prediction[s]);
    assign slotTarget[s] = (slotType[s] == CT_RETURN) ? addrRas : btbTarget[s];
  end

  // Lowest-index taken slot wins
  always_comb begin
    firstIdx = '0;
    for (int s = `SLOT_COUNT - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        firstIdx = slotIdx_t'(s);
      end
    end
  end

  assign anyTaken = |slotTaken;

  // Next-PC priority select
  always_comb begin
    predictPath = 1'b0;
    if (recoverFlag_i) begin
      nextPc = recoverPC_i;
    end else if (exceptionFlag_i) begin
      nextPc = exceptionPC_i;
    end else if (flagRecoverEX_i) begin
      nextPc = targetAddrEX_i;           // Acts even under stall
    end else if (stall_i || miss) begin
      nextPc = pc;                       // Hold
    end else if (flagRecoverID_i) begin
      nextPc = targetAddrID_i;
    end else begin
      predictPath = 1'b1;
      if (anyTaken) begin
        nextPc = slotTarget[firstIdx];
      end else begin
        nextPc = alignedPc + `BUNDLE_BYTES;  // Sequential bundle
      end
    end
  end

  // RAS push/pop only when the predicted path is followed
  assign pushRas  = predictPath && anyTaken && (slotType[firstIdx] == CT_CALL);
  assign popRas   = predictPath && anyTaken && (slotType[firstIdx] == CT_RETURN);
  assign pushAddr = alignedPc + ((`SIZE_PC'(firstIdx) + `SIZE_PC'(1)) * `SLOT_BYTES);

  // PC register
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  assign pc_o          = pc;
  assign miss_o        = miss;
  assign fs1Ready_o    = ~miss;   // Bundle usable downstream
  assign btbHit0_o     = btbHit[0];
  assign btbHit1_o     = btbHit[1];
  assign btbHit2_o     = btbHit[2];
  assign btbHit3_o     = btbHit[3];
  assign targetAddr0_o = slotTarget[0];
  assign targetAddr1_o = slotTarget[1];
  assign targetAddr2_o = slotTarget[2];
  assign targetAddr3_o = slotTarget[3];
  assign prediction0_o = prediction[0];
  assign prediction1_o = prediction[1];
  assign prediction2_o = prediction[2];
  assign prediction3_o = prediction[3];

endmodule

// ==== logic/instCache.sv ====
// ==========================================================================
// Instruction cache
// Direct-mapped, one four-instruction bundle per line, combinational
// read with tag check and a refill write port
// ==========================================================================

`timescale 1ns/100ps
`include "fetch_defines.svh"

module instCache (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`SIZE_PC-1:0]      addr_i,
  input  logic                     wrEnable_i,
  input  logic [`SIZE_PC-1:0]      wrAddr_i,
  input  logic [`BUNDLE_WIDTH-1:0] instBlock_i,
  output logic [`BUNDLE_WIDTH-1:0] instBundle_o,
  output logic                     miss_o,
  output logic [`SIZE_PC-1:0]      missAddr_o
);

  localparam int TagLsb = `BUNDLE_SHIFT + `ICACHE_INDEX_BITS;

  logic [`ICACHE_LINES-1:0]      lineValid;
  logic [`SIZE_PC-1:TagLsb]      lineTag  [`ICACHE_LINES];
  logic [`BUNDLE_WIDTH-1:0]      lineData [`ICACHE_LINES];

  logic [`ICACHE_INDEX_BITS-1:0] rdIdx;
  logic [`ICACHE_INDEX_BITS-1:0] wrIdx;
  logic                          tagMatch;

  assign rdIdx = addr_i[TagLsb-1:`BUNDLE_SHIFT];
  assign wrIdx = wrAddr_i[TagLsb-1:`BUNDLE_SHIFT];

  // Read path
  assign tagMatch     = lineValid[rdIdx] && (lineTag[rdIdx] == addr_i[`SIZE_PC-1:TagLsb]);
  assign instBundle_o = lineData[rdIdx];
  assign miss_o       = ~tagMatch;
  assign missAddr_o   = {addr_i[`SIZE_PC-1:`BUNDLE_SHIFT], {`BUNDLE_SHIFT{1'b0}}};  // Line base

  always_ff @(posedge clk) begin
    if (reset) begin
      lineValid <= '0;
    end else if (wrEnable_i) begin
      lineValid[wrIdx] <= 1'b1;
    end
  end

  // Refill writes whole line
  always_ff @(posedge clk) begin
    if (wrEnable_i) begin
      lineTag[wrIdx]  <= wrAddr_i[`SIZE_PC-1:TagLsb];
      lineData[wrIdx] <= instBlock_i;
    end
  end

endmodule

// ==== predict/branchPredictor.sv ====
// ==========================================================================
// Direction predictor
// Table of two-bit saturating counters, four slot reads per bundle and
// one in-order update per cycle
// ==========================================================================

`timescale 1ns/100ps
`include "fetch_defines.svh"

module branchPredictor import fetchPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [`SIZE_PC-1:0] pc_i,
  input  logic                updateEn_i,
  input  logic [`SIZE_PC-1:0] updatePC_i,
  input  logic                updateDir_i,
  output logic                prediction0_o,
  output logic                prediction1_o,
  output logic                prediction2_o,
  output logic                prediction3_o
);

  localparam int IdxMsb = `SLOT_SHIFT + `BP_INDEX_BITS - 1;

  logic [1:0]               counter [`BP_ENTRIES];
  logic [`SLOT_COUNT-1:0]   predict;
  logic [`BP_INDEX_BITS-1:0] updIdx;

  assign updIdx = updatePC_i[IdxMsb:`SLOT_SHIFT];  // Bits above slot stride

  for (genvar s = 0; s < `SLOT_COUNT; s++) begin : genRead
    logic [`SIZE_PC-1:0] slotPc;

    assign slotPc     = {pc_i[`SIZE_PC-1:`BUNDLE_SHIFT], slotIdx_t'(s), {`SLOT_SHIFT{1'b0}}};
    assign predict[s] = counter[slotPc[IdxMsb:`SLOT_SHIFT]][1];  // Upper bit is taken
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        counter[i] <= 2'b01;   // Weakly not-taken
      end
    end else if (updateEn_i) begin
      if (updateDir_i && (counter[updIdx] != 2'b11)) begin
        counter[updIdx] <= counter[updIdx] + 2'd1;
      end else if (!updateDir_i && (counter[updIdx] != 2'b00)) begin
        counter[updIdx] <= counter[updIdx] - 2'd1;
      end
    end
  end

  assign prediction0_o = predict[0];
  assign prediction1_o = predict[1];
  assign prediction2_o = predict[2];
  assign prediction3_o = predict[3];

endmodule

// ==== predict/btb.sv ====
// ==========================================================================
// Branch target buffer
// Four banks, one per slot position, looked up in parallel for a bundle
// and written in program order from the update port
// ==========================================================================

`timescale 1ns/100ps
`include "fetch_defines.svh"

module btb import fetchPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [`SIZE_PC-1:0] pc_i,
  input  logic                updateEn_i,
  input  logic [`SIZE_PC-1:0] updatePC_i,
  input  ctrlType_t           updateBrType_i,
  input  logic [`SIZE_PC-1:0] updateTargetAddr_i,
  output logic                btbHit0_o,
  output logic                btbHit1_o,
  output logic                btbHit2_o,
  output logic                btbHit3_o,
  output ctrlType_t           ctrlType0_o,
  output ctrlType_t           ctrlType1_o,
  output ctrlType_t           ctrlType2_o,
  output ctrlType_t           ctrlType3_o,
  output logic [`SIZE_PC-1:0] targetAddr0_o,
  output logic [`SIZE_PC-1:0] targetAddr1_o,
  output logic [`SIZE_PC-1:0] targetAddr2_o,
  output logic [`SIZE_PC-1:0] targetAddr3_o
);

  localparam int TagLsb = `BUNDLE_SHIFT + `BTB_INDEX_BITS;

  logic [`BTB_SETS-1:0]       btbValid  [`SLOT_COUNT];
  logic [`SIZE_PC-1:TagLsb]   btbTag    [`SLOT_COUNT][`BTB_SETS];
  ctrlType_t                  btbType   [`SLOT_COUNT][`BTB_SETS];
  logic [`SIZE_PC-1:0]        btbTarget [`SLOT_COUNT][`BTB_SETS];

  logic [`SLOT_COUNT-1:0]     hit;
  ctrlType_t                  hitType   [`SLOT_COUNT];
  logic [`SIZE_PC-1:0]        hitTarget [`SLOT_COUNT];

  // Update side decode
  slotIdx_t                   updBank;
  logic [`BTB_INDEX_BITS-1:0] updIdx;

  assign updBank = updatePC_i[`BUNDLE_SHIFT-1:`SLOT_SHIFT];   // Bits 4:3
  assign updIdx  = updatePC_i[TagLsb-1:`BUNDLE_SHIFT];

  // Per-bank lookup at aligned PC plus slot offset
  for (genvar b = 0; b < `SLOT_COUNT; b++) begin : genBank
    logic [`SIZE_PC-1:0]        slotPc;
    logic [`BTB_INDEX_BITS-1:0] rdIdx;

    assign slotPc       = {pc_i[`SIZE_PC-1:`BUNDLE_SHIFT], slotIdx_t'(b), {`SLOT_SHIFT{1'b0}}};
    assign rdIdx        = slotPc[TagLsb-1:`BUNDLE_SHIFT];
    assign hit[b]       = btbValid[b][rdIdx] && (btbTag[b][rdIdx] == slotPc[`SIZE_PC-1:TagLsb]);
    assign hitType[b]   = btbType[b][rdIdx];
    assign hitTarget[b] = btbTarget[b][rdIdx];
  end

  // Valid bit per entry
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < `SLOT_COUNT; b++) begin
        btbValid[b] <= '0;
      end
    end else if (updateEn_i) begin
      btbValid[updBank][updIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      btbTag[updBank][updIdx]    <= updatePC_i[`SIZE_PC-1:TagLsb];
      btbType[updBank][updIdx]   <= updateBrType_i;
      btbTarget[updBank][updIdx] <= updateTargetAddr_i;
    end
  end

  assign btbHit0_o     = hit[0];
  assign btbHit1_o     = hit[1];
  assign btbHit2_o     = hit[2];
  assign btbHit3_o     = hit[3];
  assign ctrlType0_o   = hitType[0];
  assign ctrlType1_o   = hitType[1];
  assign ctrlType2_o   = hitType[2];
  assign ctrlType3_o   = hitType[3];
  assign targetAddr0_o = hitTarget[0];
  assign targetAddr1_o = hitTarget[1];
  assign targetAddr2_o = hitTarget[2];
  assign targetAddr3_o = hitTarget[3];

endmodule

// ==== predict/returnStack.sv ====
// ==========================================================================
// Return address stack
// Circular stack of return addresses, top entry always visible,
// overflow wraps onto the oldest entry
// ==========================================================================

`timescale 1ns/100ps
`include "fetch_defines.svh"

module returnStack (
  input  logic                clk,
  input  logic                reset,
  input  logic                push_i,
  input  logic [`SIZE_PC-1:0] pushAddr_i,
  input  logic                pop_i,
  output logic [`SIZE_PC-1:0] addrRAS_o
);

  logic [`SIZE_PC-1:0]      stack [`RAS_DEPTH];
  logic [`RAS_PTR_BITS-1:0] topPtr;
  logic [`RAS_PTR_BITS-1:0] abovePtr;

  assign abovePtr = topPtr + 1'b1;  // Wraps at depth

  // Push wins if both ever arrive together
  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
    end else if (push_i) begin
      topPtr <= abovePtr;
    end else if (pop_i) begin
      topPtr <= topPtr - 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      stack[abovePtr] <= pushAddr_i;
    end
  end

  assign addrRAS_o = stack[topPtr];

endmodule

// ==== verification/fetchStage1Tb.sv ====
// ==========================================================================
// Fetch stage 1 testbench
// Replays refill, update and step cases from a data file and checks PC,
// miss, bundle data and per-slot BTB and predictor outputs after each edge
// ==========================================================================

`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetchStage1Tb import fetchPkg::*; ();

  localparam string CaseFile = "verification/fetch_cases.txt";

  logic                     clk;
  logic                     reset;
  logic                     stall;
  logic                     recoverFlag;
  logic [`SIZE_PC-1:0]      recoverPC;
  logic                     exceptionFlag;
  logic [`SIZE_PC-1:0]      exceptionPC;
  logic                     flagRecoverEX;
  logic [`SIZE_PC-1:0]      targetAddrEX;
  logic                     flagRecoverID;
  logic [`SIZE_PC-1:0]      targetAddrID;
  logic                     updateEn;
  logic [`SIZE_PC-1:0]      updatePC;
  logic [`SIZE_PC-1:0]      updateTargetAddr;
  ctrlType_t                updateBrType;
  logic                     updateDir;
  logic                     wrEnable;
  logic [`SIZE_PC-1:0]      wrAddr;
  logic [`BUNDLE_WIDTH-1:0] instBlock;

  logic [`SIZE_PC-1:0]      pc_o;
  logic [`BUNDLE_WIDTH-1:0] instructionBundle_o;
  logic                     fs1Ready_o;
  logic                     miss_o;
  logic [`SIZE_PC-1:0]      missAddr_o;
  logic                     btbHit0_o;
  logic                     btbHit1_o;
  logic                     btbHit2_o;
  logic                     btbHit3_o;
  logic [`SIZE_PC-1:0]      targetAddr0_o;
  logic [`SIZE_PC-1:0]      targetAddr1_o;
  logic [`SIZE_PC-1:0]      targetAddr2_o;
  logic [`SIZE_PC-1:0]      targetAddr3_o;
  logic                     prediction0_o;
  logic                     prediction1_o;
  logic                     prediction2_o;
  logic                     prediction3_o;

  // Reference copy of refilled lines per direct-mapped index
  logic [`ICACHE_LINES-1:0] refValid;
  logic [`SIZE_PC-1:0]      refAddr  [`ICACHE_LINES];
  logic [`BUNDLE_WIDTH-1:0] refWords [`ICACHE_LINES];

  // Reference BTB per bank and set, full PC kept for the match
  logic                     refBtbValid  [`SLOT_COUNT][`BTB_SETS];
  logic [`SIZE_PC-1:0]      refBtbPc     [`SLOT_COUNT][`BTB_SETS];
  logic [1:0]               refBtbType   [`SLOT_COUNT][`BTB_SETS];
  logic [`SIZE_PC-1:0]      refBtbTarget [`SLOT_COUNT][`BTB_SETS];
  int                       refCounter   [`BP_ENTRIES];   // 0 to 3, taken from 2

  int cycleCount = 0;
  int cycleLimit = 0;   // Zero until the case count is known
  int failCount  = 0;

  fetchStage1 DUT (
    .clk                 (clk),
    .reset               (reset),
    .stall_i             (stall),
    .recoverFlag_i       (recoverFlag),
    .recoverPC_i         (recoverPC),
    .exceptionFlag_i     (exceptionFlag),
    .exceptionPC_i       (exceptionPC),
    .flagRecoverEX_i     (flagRecoverEX),
    .targetAddrEX_i      (targetAddrEX),
    .flagRecoverID_i     (flagRecoverID),
    .targetAddrID_i      (targetAddrID),
    .updateEn_i          (updateEn),
    .updatePC_i          (updatePC),
    .updateTargetAddr_i  (updateTargetAddr),
    .updateBrType_i      (updateBrType),
    .updateDir_i         (updateDir),
    .wrEnable_i          (wrEnable),
    .wrAddr_i            (wrAddr),
    .instBlock_i         (instBlock),
    .pc_o                (pc_o),
    .instructionBundle_o (instructionBundle_o),
    .fs1Ready_o          (fs1Ready_o),
    .miss_o              (miss_o),
    .missAddr_o          (missAddr_o),
    .btbHit0_o           (btbHit0_o),
    .btbHit1_o           (btbHit1_o),
    .btbHit2_o           (btbHit2_o),
    .btbHit3_o           (btbHit3_o),
    .targetAddr0_o       (targetAddr0_o),
    .targetAddr1_o       (targetAddr1_o),
    .targetAddr2_o       (targetAddr2_o),
    .targetAddr3_o       (targetAddr3_o),
    .prediction0_o       (prediction0_o),
    .prediction1_o       (prediction1_o),
    .prediction2_o       (prediction2_o),
    .prediction3_o       (prediction3_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  task automatic abortRun();
    $display("TEST FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic checkValue(input string name, input logic [127:0] actual,
                            input logic [127:0] expected);
    if (actual !== expected) begin
      failCount++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      abortRun();
    end
  endtask

  // Watchdog on total cycles
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      abortRun();
    end
  end

  task automatic driveIdle();
    stall            = 1'b0;
    recoverFlag      = 1'b0;
    recoverPC        = '0;
    exceptionFlag    = 1'b0;
    exceptionPC      = '0;
    flagRecoverEX    = 1'b0;
    targetAddrEX     = '0;
    flagRecoverID    = 1'b0;
    targetAddrID     = '0;
    updateEn         = 1'b0;
    updatePC         = '0;
    updateTargetAddr = '0;
    updateBrType     = CT_RETURN;
    updateDir        = 1'b0;
    wrEnable         = 1'b0;
    wrAddr           = '0;
    instBlock        = '0;
  endtask

  // Empty lines, empty BTB, counters weakly not-taken
  task automatic clearReference();
    refValid = '0;
    for (int b = 0; b < `SLOT_COUNT; b++) begin
      for (int s = 0; s < `BTB_SETS; s++) begin
        refBtbValid[b][s] = 1'b0;
      end
    end
    for (int i = 0; i < `BP_ENTRIES; i++) begin
      refCounter[i] = 1;
    end
  endtask

  task automatic skipLine(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  // Lines not starting with # are cases
  task automatic countCaseLines(output int count);
    int         fd;
    logic [7:0] kind;
    count = 0;
    fd = $fopen(CaseFile, "r");
    if (fd != 0) begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        if (kind != "#") begin
          count++;
        end
        skipLine(fd);
      end
      $fclose(fd);
    end
  endtask

  // Refill and update hold the PC with stall for their cycle
  task automatic applyRefill(input logic [31:0] addr, input logic [127:0] block);
    int idx;
    idx       = addr[8:5];   // Line index
    wrEnable  = 1'b1;
    wrAddr    = addr;
    instBlock = block;
    stall     = 1'b1;
    @(posedge clk);
    #1;
    driveIdle();
    refValid[idx] = 1'b1;
    refAddr[idx]  = {addr[31:5], 5'b0};
    refWords[idx] = block;
  endtask

  task automatic applyUpdate(input logic [31:0] pc, input logic [31:0] target,
                             input logic [1:0] brType, input logic dir);
    logic [1:0] bank;
    logic [2:0] setIdx;
    logic [5:0] ctrIdx;
    bank             = pc[4:3];   // Slot position
    setIdx           = pc[7:5];
    ctrIdx           = pc[8:3];   // One counter per instruction
    updateEn         = 1'b1;
    updatePC         = pc;
    updateTargetAddr = target;
    updateBrType     = ctrlType_t'(brType);
    updateDir        = dir;
    stall            = 1'b1;
    @(posedge clk);
    #1;
    driveIdle();
    // Not-taken conditionals stay out of the BTB
    if (brType != CT_COND || dir) begin
      refBtbValid[bank][setIdx]  = 1'b1;
      refBtbPc[bank][setIdx]     = pc;
      refBtbType[bank][setIdx]   = brType;
      refBtbTarget[bank][setIdx] = target;
    end
    if (brType == CT_COND) begin
      if (dir && refCounter[ctrIdx] < 3) begin
        refCounter[ctrIdx]++;
      end else if (!dir && refCounter[ctrIdx] > 0) begin
        refCounter[ctrIdx]--;
      end
    end
  endtask

  // Raw per-slot lookups for the bundle at pc
  task automatic checkSlots(input logic [31:0] pc);
    logic [31:0] slotPc;
    logic [2:0]  setIdx;
    logic        expHit;
    logic [3:0]  hits;
    logic [3:0]  preds;
    logic [31:0] targets [4];
    hits       = {btbHit3_o, btbHit2_o, btbHit1_o, btbHit0_o};
    preds      = {prediction3_o, prediction2_o, prediction1_o, prediction0_o};
    targets[0] = targetAddr0_o;
    targets[1] = targetAddr1_o;
    targets[2] = targetAddr2_o;
    targets[3] = targetAddr3_o;
    for (int s = 0; s < `SLOT_COUNT; s++) begin
      slotPc = {pc[31:5], 5'b0} + s * 8;
      setIdx = slotPc[7:5];
      expHit = refBtbValid[s][setIdx] && (refBtbPc[s][setIdx] == slotPc);
      checkValue($sformatf("btbHit%0d_o", s), hits[s], expHit);
      checkValue($sformatf("prediction%0d_o", s), preds[s], refCounter[slotPc[8:3]] >= 2);
      // Return targets come from the RAS
      if (expHit && refBtbType[s][setIdx] != CT_RETURN) begin
        checkValue($sformatf("targetAddr%0d_o", s), targets[s], refBtbTarget[s][setIdx]);
      end
    end
  endtask

  // PC and miss come from the case and the rest from cache rules
  task automatic checkOutputs(input logic [31:0] expPc, input logic expMiss);
    logic [31:0] lineBase;
    int          idx;
    lineBase = {expPc[31:5], 5'b0};
    idx      = expPc[8:5];
    checkValue("pc_o", pc_o, expPc);
    checkValue("miss_o", miss_o, expMiss);
    checkValue("missAddr_o", missAddr_o, lineBase);
    checkValue("fs1Ready_o", fs1Ready_o, !expMiss);
    if (!expMiss) begin
      if (!refValid[idx] || refAddr[idx] != lineBase) begin
        $display("Case expects a hit at %h but that line was never refilled", expPc);
        abortRun();
      end else begin
        checkValue("instructionBundle_o", instructionBundle_o, refWords[idx]);
      end
    end
    checkSlots(expPc);
  endtask

  task automatic applyStep(input logic stallV, input logic recV, input logic [31:0] recPc,
                           input logic excV, input logic [31:0] excPc,
                           input logic exV, input logic [31:0] exPc,
                           input logic idV, input logic [31:0] idPc,
                           input logic [31:0] expPc, input logic expMiss);
    stall         = stallV;
    recoverFlag   = recV;
    recoverPC     = recPc;
    exceptionFlag = excV;
    exceptionPC   = excPc;
    flagRecoverEX = exV;
    targetAddrEX  = exPc;
    flagRecoverID = idV;
    targetAddrID  = idPc;
    @(posedge clk);
    #1;
    driveIdle();
    checkOutputs(expPc, expMiss);
  endtask

  task automatic runCases(input int fd);
    logic [7:0]  kind;
    logic [31:0] f [12];   // Numeric fields of one line
    logic        stopRead;
    stopRead = 1'b0;
    while (!stopRead && $fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": skipLine(fd);
        "R": begin
          stopRead = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]) != 5;
          if (!stopRead) applyRefill(f[0], {f[4], f[3], f[2], f[1]});   // Slot 0 low
        end
        "U": begin
          stopRead = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]) != 4;
          if (!stopRead) applyUpdate(f[0], f[1], f[2][1:0], f[3][0]);
        end
        "S": begin
          stopRead = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                             f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]) != 11;
          if (!stopRead) applyStep(f[0][0], f[1][0], f[2], f[3][0], f[4], f[5][0], f[6],
                                   f[7][0], f[8], f[9], f[10][0]);
        end
        "P": begin
          stopRead = $fscanf(fd, "%h", f[0]) != 1;
          if (!stopRead) checkValue("prediction0_o", prediction0_o, f[0][0]);
        end
        "T": begin
          stopRead = $fscanf(fd, "%h", f[0]) != 1;
          if (!stopRead) checkValue("targetAddr0_o", targetAddr0_o, f[0]);
        end
        default: begin
          $display("Unknown case kind '%c' in the case file", kind);
          stopRead = 1'b1;
        end
      endcase
      if (stopRead) begin
        $display("Case file could not be parsed");
        failCount++;
      end
    end
  endtask

  initial begin
    int fd;
    int caseLines;
    driveIdle();
    reset = 1'b1;
    clearReference();
    countCaseLines(caseLines);
    cycleLimit = caseLines * 4 + 50;
    repeat (5) @(posedge clk);   // Reset held 5 cycles
    #1;
    reset = 1'b0;
    fd = $fopen(CaseFile, "r");
    if (fd == 0) begin
      $display("Cannot open the case file %s", CaseFile);
      abortRun();
    end else begin
      runCases(fd);
      $fclose(fd);
      if (failCount == 0) begin
        $display("TEST PASSED");
        $finish;
      end else begin
        abortRun();
      end
    end
  end

endmodule

// ==== verification/fetch_cases.txt ====
# R addr w0 w1 w2 w3 | U pc target type(0 ret 1 call 2 jump 3 cond) dir | P pred0 | T target0
# S stall rec recPC exc excPC ex exPC id idPC expPC expMiss   (all hex)
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000000 1
R 00000000 00000013 00100093 00200113 00300193
S 1 0 00000000 0 00000000 0 00000000 0 00000000 00000000 0
R 00000020 01000013 01100093 01200113 01300193
R 00000040 02000013 02100093 02200113 02300193
R 00000060 03000013 03100093 03200113 03300193
R 000000a0 05000013 05100093 05200113 05300193
R 000000c0 06000013 06100093 06200113 06300193
R 000000e0 07000013 07100093 07200113 07300193
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000020 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000040 0
S 1 0 00000000 0 00000000 0 00000000 0 00000000 00000040 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000060 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000080 1
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000080 1
R 00000080 04000013 04100093 04200113 04300193
U 00000088 00000040 2 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000040 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000060 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000080 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000040 0
S 0 0 00000000 0 00000000 0 00000000 1 00000090 00000090 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 000000a0 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 000000c0 0
P 0
U 000000c0 00000020 3 1
P 1
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000020 0
U 000000c0 00000020 3 0
U 000000c0 00000020 3 0
S 0 0 00000000 0 00000000 0 00000000 1 000000c0 000000c0 0
P 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 000000e0 0
R 00000100 08000013 08100093 08200113 08300193
U 000000e8 00000100 1 0
U 00000100 00000000 0 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 00000100 0
T 000000f0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 000000f0 0
S 0 1 00000040 1 00000060 1 00000080 1 000000a0 00000040 0
S 0 0 00000000 1 00000060 1 00000080 1 000000a0 00000060 0
S 0 0 00000000 0 00000000 1 00000080 1 000000a0 00000080 0
S 1 0 00000000 0 00000000 1 00000020 0 00000000 00000020 0
S 1 0 00000000 0 00000000 0 00000000 1 000000a0 00000020 0
S 0 0 00000000 0 00000000 0 00000000 1 000000a0 000000a0 0
S 0 0 00000000 0 00000000 0 00000000 0 00000000 000000c0 0
